//--- hw/ptp_td_cfg.svh
// time distribution leaf constants
`ifndef PTP_TD_CFG_SVH
`define PTP_TD_CFG_SVH

`default_nettype none

// serial word format
`define TD_WORD_W 16
`define TD_INDEX_W 4
`define TD_MSG_W 4

// time of day format
`define TOD_S_W 48
`define TOD_NS_W 30
`define FNS_W 16
`define PERIOD_NS_W 8

`define NS_PER_S 31'd1_000_000_000
`define PPS_STR_CLEAR_BIT 29
`define MISMATCH_LIMIT 4

`default_nettype wire

`endif

//--- hw/ptp_td_leaf.sv
// PTP time distribution leaf
`timescale 1ns/1ps
`include "ptp_td_cfg.svh"
`default_nettype none

module ptp_td_leaf import ptp_td_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sdi,
    output logic [`TOD_S_W+2+`TOD_NS_W+`FNS_W-1:0] ts_tod,
    output logic      tod_step,
    output logic      pps,
    output logic      pps_str
);

    td_word_t word;
    logic word_valid;
    period_t period;
    tod_shadow_t shadow;
    logic shadow_valid;

    td_deserializer u_deser (
        .clk(clk),
        .rst(rst),
        .sdi(sdi),
        .word(word),
        .word_valid(word_valid)
    );

    td_shadow_regs u_shadow (
        .clk(clk),
        .rst(rst),
        .word(word),
        .word_valid(word_valid),
        .period(period),
        .shadow(shadow),
        .shadow_valid(shadow_valid)
    );

    tod_counter u_tod (
        .clk(clk),
        .rst(rst),
        .period(period),
        .shadow(shadow),
        .shadow_valid(shadow_valid),
        .ts_tod(ts_tod),
        .tod_step(tod_step),
        .pps(pps),
        .pps_str(pps_str)
    );

endmodule

`default_nettype wire

//--- hw/ptp_td_pkg.sv
// time distribution leaf types
`include "ptp_td_cfg.svh"
`default_nettype none

package ptp_td_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_sep
    } td_state_e;

    // word index within a frame
    typedef enum logic [`TD_INDEX_W-1:0] {
        w_flags      = 0,
        w_tod_ns_lo  = 1,
        w_tod_ns_hi  = 2,
        w_tod_s_lo   = 3,
        w_tod_s_mid  = 4,
        w_tod_s_hi   = 5,
        w_period_fns = 11,
        w_period_ns  = 12
    } td_word_e;

    typedef struct packed {
        logic [`TD_WORD_W-1:0] data;
        td_word_e              index;
        logic [`TD_MSG_W-1:0]  msg;
        logic                  last;
    } td_word_t;

    typedef struct packed {
        logic [`TOD_S_W-1:0]  s;
        logic [`TOD_NS_W-1:0] ns;
    } tod_time_t;

    typedef struct packed {
        logic [`PERIOD_NS_W-1:0] ns;
        logic [`FNS_W-1:0]       fns;
    } period_t;

    typedef struct packed {
        tod_time_t tod;
        logic      step;
    } tod_shadow_t;

endpackage

`default_nettype wire

//--- hw/td_deserializer.sv
// serial time data deserializer
`timescale 1ns/1ps
`include "ptp_td_cfg.svh"
`default_nettype none

module td_deserializer import ptp_td_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sdi,
    output td_word_t  word,
    output logic      word_valid
);

    td_state_e state_reg;
    logic [`TD_WORD_W-1:0] shift_reg;
    logic [3:0] bit_cnt_reg;
    logic [`TD_INDEX_W-1:0] index_reg;
    logic [`TD_MSG_W-1:0] msg_reg;

    always_ff @(posedge clk) begin
        word_valid <= 1'b0;

        case (state_reg)
            st_idle: begin
                // a low bit on the idle high line starts a word
                if (!sdi) begin
                    bit_cnt_reg <= '0;
                    state_reg <= st_data;
                end
            end
            st_data: begin
                // lsb first
                shift_reg <= {sdi, shift_reg[`TD_WORD_W-1:1]};
                bit_cnt_reg <= bit_cnt_reg + 4'd1;
                if (bit_cnt_reg == 4'(`TD_WORD_W - 1)) begin
                    state_reg <= st_sep;
                end
            end
            st_sep: begin
                word.data <= shift_reg;
                word.index <= td_word_e'(index_reg);
                word.msg <= msg_reg;
                word.last <= sdi;
                word_valid <= 1'b1;

                // message number comes from word 0 and covers the whole frame
                if (index_reg == w_flags) begin
                    msg_reg <= shift_reg[`TD_MSG_W-1:0];
                    word.msg <= shift_reg[`TD_MSG_W-1:0];
                end

                if (sdi) begin
                    index_reg <= '0;
                    state_reg <= st_idle;
                end else begin
                    // separator low doubles as next start bit
                    index_reg <= index_reg + `TD_INDEX_W'(1);
                    bit_cnt_reg <= '0;
                    state_reg <= st_data;
                end
            end
            default: state_reg <= st_idle;
        endcase

        if (rst) begin
            state_reg <= st_idle;
            bit_cnt_reg <= '0;
            index_reg <= '0;
            msg_reg <= '0;
            word_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/td_shadow_regs.sv
// message 0 shadow registers
`timescale 1ns/1ps
`include "ptp_td_cfg.svh"
`default_nettype none

module td_shadow_regs import ptp_td_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire td_word_t word,
    input  wire logic     word_valid,
    output period_t       period,
    output tod_shadow_t   shadow,
    output logic          shadow_valid
);

    logic pend_reg;
    logic msg0;

    assign msg0 = word_valid && (word.msg == '0);

    always_ff @(posedge clk) begin
        // strobe one cycle after the last seconds word lands
        shadow_valid <= pend_reg;
        if (pend_reg) begin
            pend_reg <= 1'b0;
        end

        // step flag is consumed along with the strobe
        if (shadow_valid) begin
            shadow.step <= 1'b0;
        end

        if (msg0) begin
            case (word.index)
                w_tod_ns_lo: begin
                    shadow.tod.ns[15:0] <= word.data;
                    pend_reg <= 1'b0;
                end
                w_tod_ns_hi: begin
                    shadow.tod.ns[`TOD_NS_W-1:16] <= word.data[`TOD_NS_W-17:0];
                    shadow.step <= shadow.step | word.data[15];
                end
                w_tod_s_lo: begin
                    shadow.tod.s[15:0] <= word.data;
                end
                w_tod_s_mid: begin
                    shadow.tod.s[31:16] <= word.data;
                end
                w_tod_s_hi: begin
                    shadow.tod.s[`TOD_S_W-1:32] <= word.data;
                    pend_reg <= 1'b1;
                end
                w_period_fns: begin
                    period.fns <= word.data;
                end
                w_period_ns: begin
                    period.ns <= word.data[`PERIOD_NS_W-1:0];
                end
                default: ;
            endcase
        end

        if (rst) begin
            period <= '0;
            shadow.step <= 1'b0;
            pend_reg <= 1'b0;
            shadow_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/tod_counter.sv
// time of day counter
`timescale 1ns/1ps
`include "ptp_td_cfg.svh"
`default_nettype none

module tod_counter import ptp_td_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire period_t     period,
    input  wire tod_shadow_t shadow,
    input  wire logic        shadow_valid,
    output logic [`TOD_S_W+2+`TOD_NS_W+`FNS_W-1:0] ts_tod,
    output logic             tod_step,
    output logic             pps,
    output logic             pps_str
);

    tod_time_t tod_reg, tod_next;
    logic [`FNS_W-1:0] fns_reg, fns_next;
    logic step_next;
    logic pps_next;
    logic pps_str_next;
    logic [1:0] mismatch_reg, mismatch_next;
    logic load_pend_reg, load_pend_next;

    // one extra bit to catch the second rollover
    logic [`TOD_NS_W:0] ns_sum;
    logic [`FNS_W-1:0] fns_sum;

    assign ts_tod = {tod_reg.s, 2'b00, tod_reg.ns, fns_reg};

    always_comb begin
        {ns_sum, fns_sum} = {1'b0, tod_reg.ns, fns_reg}
            + {{(`TOD_NS_W + 1 - `PERIOD_NS_W){1'b0}}, period};

        tod_next = tod_reg;
        fns_next = fns_sum;
        step_next = 1'b0;
        pps_next = 1'b0;
        pps_str_next = pps_str;
        mismatch_next = mismatch_reg;
        load_pend_next = load_pend_reg;

        if (tod_reg.ns[`PPS_STR_CLEAR_BIT]) begin
            pps_str_next = 1'b0;
        end

        if (ns_sum >= `NS_PER_S) begin
            tod_next.ns = `TOD_NS_W'(ns_sum - `NS_PER_S);
            tod_next.s = tod_reg.s + `TOD_S_W'(1);
            pps_next = 1'b1;
            pps_str_next = 1'b1;
        end else begin
            tod_next.ns = `TOD_NS_W'(ns_sum);
        end

        if (shadow_valid) begin
            if (shadow.step || load_pend_reg) begin
                tod_next = shadow.tod;
                fns_next = '0;
                step_next = 1'b1;
                load_pend_next = 1'b0;
                mismatch_next = '0;
            end else if (shadow.tod.s != tod_reg.s) begin
                // persistent disagreement forces a reload on the next frame
                if (mismatch_reg == 2'(`MISMATCH_LIMIT - 1)) begin
                    load_pend_next = 1'b1;
                    mismatch_next = '0;
                end else begin
                    mismatch_next = mismatch_reg + 2'd1;
                end
            end else begin
                mismatch_next = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        tod_reg <= tod_next;
        fns_reg <= fns_next;
        tod_step <= step_next;
        pps <= pps_next;
        pps_str <= pps_str_next;
        mismatch_reg <= mismatch_next;
        load_pend_reg <= load_pend_next;

        if (rst) begin
            tod_reg <= '0;
            fns_reg <= '0;
            tod_step <= 1'b0;
            pps <= 1'b0;
            pps_str <= 1'b0;
            mismatch_reg <= '0;
            load_pend_reg <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the leaf testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_ptp_td_leaf \
    -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vtb_ptp_td_leaf > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log \
    && echo "run ok" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

//--- verification/tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/tb_ptp_td_leaf.sv
// PTP leaf testbench
`timescale 1ns/1ps
`include "ptp_td_cfg.svh"
`default_nettype none

module tb_ptp_td_leaf;

    localparam int TS_W = `TOD_S_W + 2 + `TOD_NS_W + `FNS_W;

    logic clk;
    logic rst;
    logic sdi;
    logic [TS_W-1:0] ts_tod;
    logic tod_step;
    logic pps;
    logic pps_str;

    logic [31:0] lfsr;
    logic [`PERIOD_NS_W-1:0] per_ns;
    logic [`FNS_W-1:0] per_fns;
    logic step_ok;
    logic track;
    logic [TS_W-1:0] prev_ts;
    logic prev_str;

    tb_clock_gen clock_gen (
        .clk(clk),
        .rst(rst)
    );

    ptp_td_leaf UUT (
        .clk(clk),
        .rst(rst),
        .sdi(sdi),
        .ts_tod(ts_tod),
        .tod_step(tod_step),
        .pps(pps),
        .pps_str(pps_str)
    );

    task automatic check_eq(input string name, input logic [TS_W-1:0] exp,
                            input logic [TS_W-1:0] act);
        assert (act == exp) else begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timed out waiting for %s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    pps_with_str: assert property (@(posedge clk) disable iff (rst) pps |-> pps_str)
        else begin
            $display("pps pulsed while pps_str was low");
            $display("SIMULATION FAILED");
            $fatal(1);
        end

    // a step outside a step frame window is an error
    step_allowed: assert property (@(posedge clk) disable iff (rst) tod_step |-> step_ok)
        else begin
            $display("tod_step pulsed where no time load was expected");
            $display("SIMULATION FAILED");
            $fatal(1);
        end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val = {val[62:0], lfsr[0]};
        end
    endtask

    task automatic send_frame(input logic [3:0] msg, input logic [`TOD_S_W-1:0] s,
                              input logic [`TOD_NS_W-1:0] ns, input logic step,
                              input int nwords, input logic [`PERIOD_NS_W-1:0] p_ns,
                              input logic [`FNS_W-1:0] p_fns);
        logic [`TD_WORD_W-1:0] data;
        int w;
        int b;
        @(negedge clk);
        sdi = 1'b0;
        for (w = 0; w < nwords; w++) begin
            case (w)
                0: data = {12'h0, msg};
                1: data = ns[15:0];
                2: data = {step, 1'b0, ns[29:16]};
                3: data = s[15:0];
                4: data = s[31:16];
                5: data = s[47:32];
                11: data = p_fns;
                12: data = {8'h0, p_ns};
                default: data = 16'h0;
            endcase
            for (b = 0; b < `TD_WORD_W; b++) begin
                @(negedge clk);
                sdi = data[b];
            end
            @(negedge clk);
            // high separator ends the frame and the line stays idle
            sdi = (w == nwords - 1);
        end
    endtask

    // load is due three edges after the final separator
    task automatic expect_step(input string name, input logic [`TOD_S_W-1:0] s,
                               input logic [`TOD_NS_W-1:0] ns);
        int n;
        n = 0;
        while (!tod_step && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (!tod_step) stop_on_timeout("tod_step");
        check_eq({name, " latency"}, TS_W'(4), TS_W'(n));
        check_eq({name, " time"}, {s, 2'b00, ns, 16'h0}, ts_tod);
        @(negedge clk);
        check_eq({name, " pulse"}, '0, TS_W'(tod_step));
    endtask

    // reference time of day checked every cycle once the period is known
    always @(negedge clk) begin : time_model
        logic [`TOD_NS_W+`FNS_W:0] sum;
        logic [`TOD_S_W-1:0] s_exp;
        logic wrap;
        logic str_exp;
        sum = {1'b0, prev_ts[`TOD_NS_W+`FNS_W-1:0]} + {23'd0, per_ns, per_fns};
        s_exp = prev_ts[TS_W-1:TS_W-`TOD_S_W];
        wrap = (sum[`TOD_NS_W+`FNS_W:`FNS_W] >= `NS_PER_S);
        if (wrap) begin
            sum = sum - {`NS_PER_S, 16'h0};
            s_exp = s_exp + 48'd1;
        end
        str_exp = wrap ? 1'b1 : (prev_ts[`FNS_W+`PPS_STR_CLEAR_BIT] ? 1'b0 : prev_str);
        if (track && !rst) begin
            check_eq("pps", TS_W'(wrap), TS_W'(pps));
            check_eq("pps_str", TS_W'(str_exp), TS_W'(pps_str));
            if (!tod_step) begin
                check_eq("advance", {s_exp, 2'b00, sum[`TOD_NS_W+`FNS_W-1:0]}, ts_tod);
            end
        end
        prev_ts = ts_tod;
        prev_str = pps_str;
    end

    initial begin : stimulus
        int n;
        int k;
        logic [63:0] r;
        logic [`TOD_S_W-1:0] s;
        logic [`TOD_S_W-1:0] s_bad;
        logic [`TOD_NS_W-1:0] ns;
        sdi = 1'b1;
        lfsr = 32'hf210;
        per_ns = 8'd6;
        per_fns = 16'h4000;
        step_ok = 1'b0;
        track = 1'b0;

        n = 0;
        while (rst !== 1'b0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) stop_on_timeout("reset release");
        for (n = 0; n < 20; n++) begin
            @(negedge clk);
            check_eq("reset ts_tod", '0, ts_tod);
            check_eq("reset outputs", '0, TS_W'({tod_step, pps, pps_str}));
        end

        // period words plus a first time load
        take_bits(48, r);
        s = r[`TOD_S_W-1:0];
        take_bits(28, r);
        ns = r[`TOD_NS_W-1:0];
        step_ok = 1'b1;
        send_frame(4'd0, s, ns, 1'b1, 13, per_ns, per_fns);
        repeat (4) @(negedge clk);
        track = 1'b1;

        take_bits(48, r);
        s = r[`TOD_S_W-1:0];
        take_bits(28, r);
        ns = r[`TOD_NS_W-1:0];
        send_frame(4'd0, s, ns, 1'b1, 6, per_ns, per_fns);
        expect_step("step load", s, ns);
        repeat (20) @(negedge clk);

        // a few periods short of one second
        ns = `TOD_NS_W'(`NS_PER_S - 31'd20);
        send_frame(4'd0, s, ns, 1'b1, 6, per_ns, per_fns);
        expect_step("wrap load", s, ns);
        n = 0;
        while (!pps && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!pps) stop_on_timeout("pps");
        check_eq("wrap seconds", TS_W'(s + 48'd1), TS_W'(ts_tod[TS_W-1:TS_W-`TOD_S_W]));
        s = s + 48'd1;
        ns = 30'd600_000_000;
        send_frame(4'd0, s, ns, 1'b1, 6, per_ns, per_fns);
        expect_step("bit 29 load", s, ns);
        repeat (2) @(negedge clk);
        check_eq("pps_str cleared", '0, TS_W'(pps_str));

        step_ok = 1'b0;
        send_frame(4'd0, s, 30'd0, 1'b0, 6, per_ns, per_fns);
        repeat (8) @(negedge clk);

        for (k = 1; k <= 5; k++) begin
            take_bits(28, r);
            ns = r[`TOD_NS_W-1:0];
            s_bad = s + 48'(k * 1000);
            step_ok = (k == 5);
            send_frame(4'd0, s_bad, ns, 1'b0, 6, per_ns, per_fns);
            if (k == 5) begin
                expect_step("mismatch reload", s_bad, ns);
            end
            repeat (8) @(negedge clk);
        end

        // message 1 must leave time and period alone
        step_ok = 1'b0;
        send_frame(4'd1, s, ns, 1'b1, 13, 8'd9, 16'h0);
        repeat (30) @(negedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
hw/ptp_td_pkg.sv
hw/td_deserializer.sv
hw/td_shadow_regs.sv
hw/tod_counter.sv
hw/ptp_td_leaf.sv
verification/tb_clock_gen.sv
verification/tb_ptp_td_leaf.sv
